// File: include/lsu_macros.svh
// address, cache geometry and store buffer size macros for the lsu
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// byte address width
`define LSU_ADDR_W 32

// direct mapped data cache, one line per set
`define LSU_LINE_WORDS 4
`define LSU_SETS 16
`define LSU_OFS_W 2       // word select inside a line
`define LSU_IDX_LSB 4     // set index is addr[7:4]
`define LSU_IDX_W 4
`define LSU_TAG_W 24      // tag is addr[31:8]

// write-through store buffer
`define LSU_SB_DEPTH 4

`endif

// File: verilog/lsu_pkg.sv
// request, response, store buffer entry and wishbone types plus fsm state enum
`default_nettype none
`include "lsu_macros.svh"

package lsu_pkg;

    typedef struct packed {
        logic                   we;     // store when set
        logic [1:0]             size;   // 0 byte, 1 half, 2 word
        logic [`LSU_ADDR_W-1:0] addr;
        logic [31:0]            wdata;  // already on its byte lanes
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] rdata;  // whole aligned word
        logic        ale;    // alignment exception
    } lsu_resp_t;

    // one buffered store, always inside a single word
    typedef struct packed {
        logic [`LSU_ADDR_W-3:0] waddr;
        logic [3:0]             strb;
        logic [31:0]            data;
    } sb_entry_t;

    // wishbone classic master outputs
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`LSU_ADDR_W-1:0] adr;
        logic [31:0]            dat;
        logic [3:0]             sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        S_NORMAL,  // hits flow, drains run
        S_WAITSB,  // store waits on buffer space or a buffered word
        S_REFILL   // load miss, line fetch in progress
    } fsm_e;

endpackage

`default_nettype wire

// File: verilog/lsu_beat_counter.sv
// refill beat counter giving the word index and last beat flag
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_beat_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clr_i,
    input  logic                  en_i,
    output logic [`LSU_OFS_W-1:0] idx_o,
    output logic                  last_o
);

    localparam int unsigned LAST_BEAT = `LSU_LINE_WORDS - 1;

    logic [`LSU_OFS_W-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (!rst_n || clr_i) begin
            cnt_q <= '0;
        end else if (en_i) begin
            cnt_q <= cnt_q + 1'b1;   // wraps after the last word
        end
    end

    // combinational outputs, index is valid in the beat itself
    assign idx_o  = cnt_q;
    assign last_o = (cnt_q == LAST_BEAT[`LSU_OFS_W-1:0]);

endmodule

`default_nettype wire

// File: verilog/lsu_cache_array.sv
// direct mapped tag, valid and data storage with registered read, refill and drain writes
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_cache_array (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [`LSU_IDX_W-1:0]            rd_index_i,
    input  logic                             refill_we_i,
    input  logic [`LSU_ADDR_W-1:0]           refill_addr_i,
    input  logic [`LSU_OFS_W-1:0]            refill_word_i,
    input  logic                             refill_last_i,
    input  logic [31:0]                      refill_data_i,
    input  logic                             st_we_i,
    input  lsu_pkg::sb_entry_t               st_entry_i,
    output logic [`LSU_TAG_W-1:0]            rd_tag_o,
    output logic                             rd_valid_o,
    output logic [`LSU_LINE_WORDS-1:0][31:0] rd_data_o
);

    logic [`LSU_TAG_W-1:0]            tag_q [`LSU_SETS];
    logic [`LSU_LINE_WORDS-1:0][31:0] data_q [`LSU_SETS];
    logic [`LSU_SETS-1:0]             valid_q;
    logic [`LSU_IDX_W-1:0]            idx_q, ref_idx, st_idx;
    logic [`LSU_OFS_W-1:0]            st_word;
    logic                             st_hit;

    assign ref_idx = refill_addr_i[`LSU_IDX_LSB +: `LSU_IDX_W];
    assign st_idx  = st_entry_i.waddr[`LSU_IDX_LSB-2 +: `LSU_IDX_W];
    assign st_word = st_entry_i.waddr[`LSU_OFS_W-1:0];
    // write-through, no allocate: only touch a resident line
    assign st_hit  = st_we_i && valid_q[st_idx]
                  && (tag_q[st_idx] == st_entry_i.waddr[`LSU_ADDR_W-3 -: `LSU_TAG_W]);

    always_ff @(posedge clk) begin
        if (!rst_n) valid_q <= '0;
        else if (refill_we_i) valid_q[ref_idx] <= refill_last_i;  // usable once complete
    end

    always_ff @(posedge clk) begin
        idx_q <= rd_index_i;
        if (refill_we_i) begin
            tag_q[ref_idx]                 <= refill_addr_i[`LSU_ADDR_W-1 -: `LSU_TAG_W];
            data_q[ref_idx][refill_word_i] <= refill_data_i;
        end
        if (st_hit) begin
            for (int b = 0; b < 4; b++) begin
                if (st_entry_i.strb[b]) begin
                    data_q[st_idx][st_word][b*8 +: 8] <= st_entry_i.data[b*8 +: 8];
                end
            end
        end
    end

    // index is registered, contents read through so same-edge writes are seen
    assign rd_tag_o   = tag_q[idx_q];
    assign rd_valid_o = valid_q[idx_q];
    assign rd_data_o  = data_q[idx_q];

endmodule

`default_nettype wire

// File: verilog/lsu_store_buffer.sv
// four entry in-order store buffer with word lookup, forwarding and drain head
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_store_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push_i,
    input  lsu_pkg::sb_entry_t     entry_i,
    input  logic                   pop_i,
    input  logic [`LSU_ADDR_W-3:0] match_addr_i,
    output logic                   full_o,
    output logic                   conflict_o,
    output logic [3:0]             fwd_strb_o,
    output logic [31:0]            fwd_data_o,
    output lsu_pkg::sb_entry_t     head_o,
    output logic                   nonempty_o
);

    localparam int PTR_W = $clog2(`LSU_SB_DEPTH);

    lsu_pkg::sb_entry_t       entry_q [`LSU_SB_DEPTH];
    logic [`LSU_SB_DEPTH-1:0] valid_q;
    logic [`LSU_SB_DEPTH-1:0] match;
    logic [PTR_W-1:0]         head_q, tail_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (push_i) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= tail_q + 1'b1;
            end
            if (pop_i) begin
                valid_q[head_q] <= 1'b0;   // oldest leaves first
                head_q          <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) entry_q[tail_q] <= entry_i;
    end

    // a word is buffered at most once, so plain OR is enough
    always_comb begin
        fwd_strb_o = '0;
        fwd_data_o = '0;
        for (int i = 0; i < `LSU_SB_DEPTH; i++) begin
            match[i]   = valid_q[i] && (entry_q[i].waddr == match_addr_i);
            fwd_strb_o = fwd_strb_o | ({4{match[i]}} & entry_q[i].strb);
            fwd_data_o = fwd_data_o | ({32{match[i]}} & entry_q[i].data);
        end
    end

    assign conflict_o = |match;
    assign full_o     = &valid_q;
    assign nonempty_o = |valid_q;
    assign head_o     = entry_q[head_q];

    a_push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        push_i |-> !full_o);

    // match_addr_i carries the word of the store being pushed
    a_push_unique: assert property (@(posedge clk) disable iff (!rst_n)
        push_i |-> !conflict_o);

endmodule

`default_nettype wire

// File: verilog/lsu_miss_fsm.sv
// control fsm for stalls, line refills, store buffer drains and the wishbone master
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_miss_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stage_valid_i,
    input  logic                   miss_i,
    input  logic                   is_store_i,
    input  logic                   conflict_i,
    input  logic                   sb_full_i,
    input  logic                   resp_free_i,
    input  logic [`LSU_ADDR_W-3:0] stage_addr_i,
    input  lsu_pkg::sb_entry_t     sb_head_i,
    input  logic                   sb_nonempty_i,
    input  lsu_pkg::wb_rsp_t       wb_i,
    input  logic                   beat_last_i,
    input  logic [`LSU_OFS_W-1:0]  beat_idx_i,
    output logic                   advance_o,
    output logic                   push_o,
    output logic                   pop_o,
    output lsu_pkg::wb_req_t       wb_o,
    output logic                   refill_we_o,
    output logic [`LSU_ADDR_W-1:0] refill_addr_o,
    output logic [31:0]            refill_data_o,
    output logic                   beat_en_o,
    output logic                   beat_clr_o
);

    lsu_pkg::fsm_e    state_q, state_d;
    lsu_pkg::wb_req_t wb_q, wb_d;
    logic             ack;

    assign ack           = wb_q.cyc && wb_i.ack;
    assign wb_o          = wb_q;
    assign pop_o         = ack && wb_q.we;          // drain done
    assign push_o        = advance_o && is_store_i;
    assign refill_addr_o = wb_q.adr;
    assign refill_data_o = wb_i.dat;
    assign beat_en_o     = refill_we_o;
    assign beat_clr_o    = (state_q != lsu_pkg::S_REFILL);

    always_comb begin
        state_d     = state_q;
        advance_o   = 1'b0;
        refill_we_o = 1'b0;
        case (state_q)
            lsu_pkg::S_NORMAL: begin
                if (stage_valid_i && miss_i) begin
                    if (!wb_q.cyc) state_d = lsu_pkg::S_REFILL;  // let an open drain finish
                end else if (is_store_i && (conflict_i || sb_full_i)) begin
                    state_d = lsu_pkg::S_WAITSB;
                end else begin
                    advance_o = stage_valid_i && resp_free_i;
                end
            end
            lsu_pkg::S_WAITSB: begin
                if (!conflict_i && !sb_full_i) state_d = lsu_pkg::S_NORMAL;
            end
            default: begin
                refill_we_o = ack;
                if (ack && beat_last_i) state_d = lsu_pkg::S_NORMAL;  // request replays
            end
        endcase
    end

    // one single-beat cycle at a time, gap of one cycle after each ack
    always_comb begin
        wb_d = wb_q;
        if (ack) begin
            wb_d.cyc = 1'b0;
            wb_d.stb = 1'b0;
        end else if (!wb_q.cyc) begin
            if (state_q == lsu_pkg::S_REFILL) begin
                wb_d = '{cyc: 1'b1, stb: 1'b1, we: 1'b0,
                         adr: {stage_addr_i[`LSU_ADDR_W-3:`LSU_OFS_W], beat_idx_i, 2'b00},
                         dat: 32'd0, sel: 4'hf};
            end else if (state_d != lsu_pkg::S_REFILL && sb_nonempty_i) begin
                wb_d = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: {sb_head_i.waddr, 2'b00},
                         dat: sb_head_i.data, sel: sb_head_i.strb};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= lsu_pkg::S_NORMAL;
            wb_q    <= '0;
        end else begin
            state_q <= state_d;
            wb_q    <= wb_d;
        end
    end

    // slave sees a steady request until it acks
    a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wb_q.cyc && !wb_i.ack |=> wb_q.cyc && $stable(wb_q.adr) && $stable(wb_q.we));

endmodule

`default_nettype wire

// File: verilog/lsu_access_stage.sv
// access stage with skid register, alignment and tag check, store forwarding, response register
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_access_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             req_valid_i,
    output logic                             req_ready_o,
    input  lsu_pkg::lsu_req_t                req_i,
    output logic                             resp_valid_o,
    input  logic                             resp_ready_i,
    output lsu_pkg::lsu_resp_t               resp_o,
    input  logic                             advance_i,
    output logic [`LSU_IDX_W-1:0]            rd_index_o,
    input  logic [`LSU_TAG_W-1:0]            rd_tag_i,
    input  logic                             rd_valid_i,
    input  logic [`LSU_LINE_WORDS-1:0][31:0] rd_data_i,
    input  logic [3:0]                       fwd_strb_i,
    input  logic [31:0]                      fwd_data_i,
    output logic                             stage_valid_o,
    output logic                             miss_o,
    output logic                             is_store_o,
    output lsu_pkg::sb_entry_t               sb_entry_o,
    output logic [`LSU_ADDR_W-3:0]           match_addr_o
);

    lsu_pkg::lsu_req_t  s_req_q, k_req_q, req_nxt;
    logic               s_valid_q, k_valid_q;
    logic               take, accept;
    logic               ale, hit;
    logic [3:0]         strb;
    logic [31:0]        arr_word, merged;
    lsu_pkg::lsu_resp_t resp_d, resp_q;
    logic               resp_valid_q;

    assign req_ready_o = !k_valid_q;           // one spare slot, then stop
    assign accept      = req_valid_i && !k_valid_q;
    assign take        = !s_valid_q || advance_i;
    assign req_nxt     = k_valid_q ? k_req_q : req_i;

    // a held request keeps re-reading its own set, so refills show up
    assign rd_index_o = take ? req_nxt.addr[`LSU_IDX_LSB +: `LSU_IDX_W]
                             : s_req_q.addr[`LSU_IDX_LSB +: `LSU_IDX_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_valid_q <= 1'b0;
            k_valid_q <= 1'b0;
        end else if (take) begin
            s_valid_q <= k_valid_q || accept;
            k_valid_q <= 1'b0;
        end else if (accept) begin
            k_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) s_req_q <= req_nxt;
        if (!take && accept) k_req_q <= req_i;   // stage busy, park it
    end

    // byte lanes and alignment from size
    always_comb begin
        ale  = 1'b0;
        strb = 4'hf;
        case (s_req_q.size)
            2'd0: strb = 4'b0001 << s_req_q.addr[1:0];
            2'd1: begin
                ale  = s_req_q.addr[0];
                strb = 4'b0011 << {s_req_q.addr[1], 1'b0};
            end
            default: ale = |s_req_q.addr[1:0];
        endcase
    end

    assign hit      = rd_valid_i && (rd_tag_i == s_req_q.addr[`LSU_ADDR_W-1 -: `LSU_TAG_W]);
    assign arr_word = rd_data_i[s_req_q.addr[`LSU_IDX_LSB-1:2]];

    // buffered bytes are newer than the array
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[b*8 +: 8] = fwd_strb_i[b] ? fwd_data_i[b*8 +: 8] : arr_word[b*8 +: 8];
        end
    end

    assign stage_valid_o = s_valid_q;
    assign miss_o        = s_valid_q && !s_req_q.we && !ale && !hit;
    assign is_store_o    = s_valid_q && s_req_q.we && !ale;  // misaligned stores never buffer
    assign match_addr_o  = s_req_q.addr[`LSU_ADDR_W-1:2];
    assign sb_entry_o    = '{waddr: s_req_q.addr[`LSU_ADDR_W-1:2], strb: strb,
                             data: s_req_q.wdata};
    assign resp_d        = '{rdata: (s_req_q.we || ale) ? 32'd0 : merged, ale: ale};

    always_ff @(posedge clk) begin
        if (!rst_n) resp_valid_q <= 1'b0;
        else if (advance_i) resp_valid_q <= 1'b1;
        else if (resp_ready_i) resp_valid_q <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (advance_i) resp_q <= resp_d;
    end

    assign resp_valid_o = resp_valid_q;
    assign resp_o       = resp_q;

    // a stalled response stays put until the cpu takes it
    a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

endmodule

`default_nettype wire

// File: verilog/lsu_top.sv
// lsu top level connecting access stage, store buffer, cache array, miss fsm and beat counter
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  lsu_pkg::lsu_req_t  req_i,
    output logic               resp_valid_o,
    input  logic               resp_ready_i,
    output lsu_pkg::lsu_resp_t resp_o,
    output lsu_pkg::wb_req_t   wb_o,
    input  lsu_pkg::wb_rsp_t   wb_i
);

    logic [`LSU_IDX_W-1:0]             rd_index;
    logic [`LSU_TAG_W-1:0]             rd_tag;
    logic                              rd_valid;
    logic [`LSU_LINE_WORDS-1:0][31:0]  rd_data;
    logic                              stage_valid, miss, is_store;
    lsu_pkg::sb_entry_t                sb_entry, sb_head;
    logic [`LSU_ADDR_W-3:0]            match_addr;
    logic                              advance, push, pop;
    logic                              sb_full, conflict, sb_nonempty;
    logic [3:0]                        fwd_strb;
    logic [31:0]                       fwd_data, refill_data;
    logic                              refill_we, beat_en, beat_clr, beat_last;
    logic [`LSU_ADDR_W-1:0]            refill_addr;
    logic [`LSU_OFS_W-1:0]             beat_idx;
    logic                              resp_free;

    assign resp_free = !resp_valid_o || resp_ready_i;  // response slot frees this cycle

    lsu_access_stage i_access (
        .clk(clk), .rst_n(rst_n),
        .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_i(req_i),
        .resp_valid_o(resp_valid_o), .resp_ready_i(resp_ready_i), .resp_o(resp_o),
        .advance_i(advance), .rd_index_o(rd_index),
        .rd_tag_i(rd_tag), .rd_valid_i(rd_valid), .rd_data_i(rd_data),
        .fwd_strb_i(fwd_strb), .fwd_data_i(fwd_data),
        .stage_valid_o(stage_valid), .miss_o(miss), .is_store_o(is_store),
        .sb_entry_o(sb_entry), .match_addr_o(match_addr)
    );

    lsu_store_buffer i_sb (
        .clk(clk), .rst_n(rst_n),
        .push_i(push), .entry_i(sb_entry), .pop_i(pop), .match_addr_i(match_addr),
        .full_o(sb_full), .conflict_o(conflict),
        .fwd_strb_o(fwd_strb), .fwd_data_o(fwd_data),
        .head_o(sb_head), .nonempty_o(sb_nonempty)
    );

    lsu_cache_array i_array (
        .clk(clk), .rst_n(rst_n), .rd_index_i(rd_index),
        .refill_we_i(refill_we), .refill_addr_i(refill_addr), .refill_word_i(beat_idx),
        .refill_last_i(beat_last), .refill_data_i(refill_data),
        .st_we_i(pop), .st_entry_i(sb_head),  // drain writes land on ack
        .rd_tag_o(rd_tag), .rd_valid_o(rd_valid), .rd_data_o(rd_data)
    );

    lsu_miss_fsm i_fsm (
        .clk(clk), .rst_n(rst_n),
        .stage_valid_i(stage_valid), .miss_i(miss), .is_store_i(is_store),
        .conflict_i(conflict), .sb_full_i(sb_full), .resp_free_i(resp_free),
        .stage_addr_i(match_addr), .sb_head_i(sb_head), .sb_nonempty_i(sb_nonempty),
        .wb_i(wb_i), .beat_last_i(beat_last), .beat_idx_i(beat_idx),
        .advance_o(advance), .push_o(push), .pop_o(pop), .wb_o(wb_o),
        .refill_we_o(refill_we), .refill_addr_o(refill_addr), .refill_data_o(refill_data),
        .beat_en_o(beat_en), .beat_clr_o(beat_clr)
    );

    lsu_beat_counter i_beat (
        .clk(clk), .rst_n(rst_n), .clr_i(beat_clr), .en_i(beat_en),
        .idx_o(beat_idx), .last_o(beat_last)
    );

endmodule

`default_nettype wire

// File: tb/lsu_tb_mem.sv
// wishbone classic memory slave with random wait states over a byte array
`timescale 1ns/1ps
`default_nettype none

module lsu_tb_mem #(
    parameter int MEM_BYTES = 1024
) (
    input  logic             clk,
    input  logic             rst_n,
    input  lsu_pkg::wb_req_t wb_i,
    output lsu_pkg::wb_rsp_t wb_o
);

    logic [7:0]  mem [MEM_BYTES];
    logic        busy_q;
    logic        ack_q;
    logic [1:0]  wait_q;
    logic [31:0] dat_q;

    // pattern mixes low and high address bits
    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 29) ^ 8'(a >> 8) ^ 8'h6c;
    endfunction

    initial begin
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = fill_byte(a);
        end
    end

    always @(posedge clk) begin
        int base;
        base = int'({wb_i.adr[31:2], 2'b00}) % MEM_BYTES;
        if (!rst_n) begin
            busy_q <= 1'b0;
            ack_q  <= 1'b0;
        end else if (ack_q) begin
            ack_q  <= 1'b0;   // master drops cyc on this same edge
            busy_q <= 1'b0;
        end else if (wb_i.cyc && wb_i.stb) begin
            if (!busy_q) begin
                busy_q <= 1'b1;
                wait_q <= 2'($urandom_range(3, 0));
            end else if (wait_q != 2'd0) begin
                wait_q <= wait_q - 2'd1;
            end else begin
                ack_q <= 1'b1;
                for (int b = 0; b < 4; b++) begin
                    if (wb_i.we && wb_i.sel[b]) begin
                        mem[base + b] <= wb_i.dat[b*8 +: 8];
                    end
                    dat_q[b*8 +: 8] <= mem[base + b];
                end
            end
        end
    end

    assign wb_o = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

// File: tb/lsu_tb.sv
// lsu testbench: clock, reset, directed and random traffic, byte model and response checks
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

    localparam int MEM_BYTES = 1024;
    localparam int LIMIT     = 2000;   // cycles allowed per wait

    typedef struct packed {
        logic [31:0] addr;
        logic        load;   // data compared only for aligned loads
        logic        ale;
        logic [31:0] data;
    } exp_t;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               req_valid_i;
    logic               req_ready_o;
    logic               resp_valid_o;
    logic               resp_ready_i;
    lsu_pkg::lsu_req_t  req_i;
    lsu_pkg::lsu_resp_t resp_o;
    lsu_pkg::wb_req_t   wb_req;
    lsu_pkg::wb_rsp_t   wb_rsp;

    logic [7:0] model [MEM_BYTES];
    exp_t       exp_q [$];
    logic       backpressure = 1'b0;
    int         checks       = 0;
    int         errors       = 0;
    int         failed_tests = 0;

    lsu_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_i(req_i),
        .resp_valid_o(resp_valid_o), .resp_ready_i(resp_ready_i), .resp_o(resp_o),
        .wb_o(wb_req), .wb_i(wb_rsp)
    );

    lsu_tb_mem #(.MEM_BYTES(MEM_BYTES)) i_mem (
        .clk(clk), .rst_n(rst_n), .wb_i(wb_req), .wb_o(wb_rsp)
    );

    always #20 clk = ~clk;

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 29) ^ 8'(a >> 8) ^ 8'h6c;
    endfunction

    function automatic int word_base(input logic [31:0] addr);
        return int'({addr[31:2], 2'b00}) % MEM_BYTES;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        int base;
        base = word_base(addr);
        return {model[base + 3], model[base + 2], model[base + 1], model[base]};
    endfunction

    task automatic stop_on_hang(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("=== FAIL ===");
        $finish;
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic issue(input logic we, input logic [1:0] size, input logic [31:0] addr,
                         input logic [31:0] wdata);
        int         waited;
        logic       ale;
        logic [3:0] strb;
        waited      = 0;
        req_i       = '{we: we, size: size, addr: addr, wdata: wdata};
        req_valid_i = 1'b1;
        while (!req_ready_o) begin   // ready comes from a flop
            @(negedge clk);
            waited++;
            if (waited > LIMIT) stop_on_hang("request was never accepted");
        end
        ale  = 1'b0;
        strb = 4'hf;
        if (size == 2'd0) begin
            strb = 4'b0001 << addr[1:0];
        end else if (size == 2'd1) begin
            ale  = addr[0];
            strb = addr[1] ? 4'b1100 : 4'b0011;
        end else begin
            ale = addr[1:0] != 2'd0;
        end
        if (we && !ale) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) model[word_base(addr) + b] = wdata[b*8 +: 8];
            end
        end
        exp_q.push_back('{addr: addr, load: !we && !ale, ale: ale, data: model_word(addr)});
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    task automatic wait_idle(output int cycles);
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);   // responses are popped on falling edges
            cycles++;
            if (cycles > LIMIT) stop_on_hang("responses still missing");
        end
        @(negedge clk);
    endtask

    // drains leave cyc low for one cycle at most
    task automatic wait_drained();
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < 3) begin
            @(negedge clk);
            waited++;
            quiet = wb_req.cyc ? 0 : quiet + 1;
            if (waited > LIMIT) stop_on_hang("store buffer never drained");
        end
    endtask

    task automatic check_timing(input logic ok, input string what);
        checks++;
        if (!ok) begin
            errors++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    task automatic report_test(input string name, input int mark);
        if (errors == mark) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: FAILED with %0d errors", name, errors - mark);
        end
    endtask

    // response side, ready chosen first for the coming edge
    always @(negedge clk) begin
        exp_t e;
        if (rst_n) begin
            resp_ready_i = backpressure ? 1'($urandom_range(1, 0)) : 1'b1;
            if (resp_valid_o && resp_ready_i) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Error at %0t: response arrived with no request outstanding",
                             $time);
                end else begin
                    e = exp_q.pop_front();
                    checks++;
                    if (resp_o.ale != e.ale || (e.load && resp_o.rdata != e.data)) begin
                        errors++;
                        $display("Error at %0t: addr 0x%08h got 0x%08h ale %0b, expected 0x%08h ale %0b",
                                 $time, e.addr, resp_o.rdata, resp_o.ale, e.data, e.ale);
                    end
                end
            end
        end
    end

    initial begin
        int          cycles;
        int          mark;
        logic [31:0] addr;
        logic [1:0]  sz;
        void'($urandom(32'h337b_2c45));
        rst_n        = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        resp_ready_i = 1'b1;
        for (int i = 0; i < MEM_BYTES; i++) begin
            model[i] = fill_byte(i);
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        mark = errors;
        issue(1'b0, 2'd2, 32'h040, 32'd0);
        wait_idle(cycles);
        check_timing(cycles > 6, "first load of line 0x040 answered too fast for a refill");
        issue(1'b0, 2'd2, 32'h044, 32'd0);
        wait_idle(cycles);
        check_timing(cycles <= 2, "repeated load of line 0x040 did not hit");
        issue(1'b0, 2'd0, 32'h047, 32'd0);
        issue(1'b0, 2'd1, 32'h04a, 32'd0);
        issue(1'b0, 2'd2, 32'h0c8, 32'd0);
        wait_idle(cycles);
        report_test("1 cold and warm loads", mark);

        mark = errors;
        issue(1'b1, 2'd1, 32'h102, 32'hbeef_0000);
        issue(1'b0, 2'd2, 32'h100, 32'd0);      // miss with forwarded bytes
        issue(1'b1, 2'd0, 32'h041, 32'h0000_a500);
        issue(1'b0, 2'd2, 32'h040, 32'd0);      // resident line
        wait_idle(cycles);
        wait_drained();
        issue(1'b0, 2'd2, 32'h100, 32'd0);
        issue(1'b0, 2'd2, 32'h040, 32'd0);
        wait_idle(cycles);
        report_test("2 load after store", mark);

        mark = errors;
        issue(1'b1, 2'd0, 32'h200, 32'h0000_0011);
        issue(1'b1, 2'd0, 32'h200, 32'h0000_0022);
        issue(1'b1, 2'd1, 32'h202, 32'h3344_0000);
        issue(1'b0, 2'd2, 32'h200, 32'd0);
        wait_idle(cycles);
        wait_drained();
        issue(1'b0, 2'd2, 32'h200, 32'd0);
        wait_idle(cycles);
        report_test("3 stores to one word", mark);

        mark = errors;
        issue(1'b0, 2'd1, 32'h301, 32'd0);
        issue(1'b0, 2'd2, 32'h302, 32'd0);
        issue(1'b1, 2'd2, 32'h305, 32'hdead_beef);
        issue(1'b1, 2'd1, 32'h307, 32'h1234_5678);
        wait_idle(cycles);
        wait_drained();
        issue(1'b0, 2'd2, 32'h304, 32'd0);
        wait_idle(cycles);
        report_test("4 misaligned requests", mark);

        mark = errors;
        backpressure = 1'b1;
        for (int n = 0; n < 400; n++) begin
            addr = 32'($urandom_range(511, 0));
            sz   = 2'($urandom_range(2, 0));
            if ($urandom_range(7, 0) != 0) addr = addr & ~((32'd1 << sz) - 32'd1);
            issue(1'($urandom_range(1, 0)), sz, addr, $urandom);
            if ($urandom_range(3, 0) == 0) @(negedge clk);   // idle gap now and then
        end
        wait_idle(cycles);
        backpressure = 1'b0;
        report_test("5 random stream with back-pressure", mark);

        mark = errors;
        wait_drained();
        for (int i = 0; i < MEM_BYTES; i++) begin
            checks++;
            if (i_mem.mem[i] != model[i]) begin
                errors++;
                $display("Error at %0t: memory byte 0x%03h is 0x%02h, expected 0x%02h",
                         $time, i, i_mem.mem[i], model[i]);
            end
        end
        report_test("6 memory after drain", mark);

        $display("tests: 6 run, %0d failed; checks: %0d, errors: %0d",
                 failed_tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
verilog/lsu_pkg.sv
verilog/lsu_beat_counter.sv
verilog/lsu_cache_array.sv
verilog/lsu_store_buffer.sv
verilog/lsu_miss_fsm.sv
verilog/lsu_access_stage.sv
verilog/lsu_top.sv
tb/lsu_tb_mem.sv
tb/lsu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the lsu testbench with verilator, run it and scan the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module lsu_tb -o lsu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/lsu_sim | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0
